// ==== Makefile ====
TOP = tb_vmem

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary -j 0 --top-module $(TOP) -f tb.f -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir

// ==== tb.f ====
vmem_pkg.sv
vmem_cfg.sv
vmem_lane_sched.sv
vmem_data_ram.sv
vmem_stage.sv
vmem_top.sv
tb_vmem.sv

// ==== tb_vmem.sv ====
`timescale 1ns/1ps

module tb_vmem
  import vmem_pkg::*;
();

  logic        CLK;
  logic        nRST;
  logic        cfg_wen;
  eew_t        cfg_eew;
  logic [5:0]  cfg_vl;
  mem_req_t    req;
  logic        stall;
  logic        flush;
  logic        busy;
  rob_result_t rob_out;
  scalar_wb_t  wb_out;

  logic [31:0] fld [17];     // Fields of the current golden record
  logic [31:0] lfsr;
  int          cycles;
  int          limit;
  int          stall_for;    // Pending stall directive
  int          flush_after;  // Pending flush directive

  vmem_top #(
    .RAM_WORDS(256),
    .VL_MAX(32)
  ) UUT (
    .CLK, .nRST, .cfg_wen, .cfg_eew, .cfg_vl, .req, .stall, .flush,
    .busy, .rob_out, .wb_out
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycles = cycles + 1;
    if (limit > 0 && cycles > limit) abort($sformatf("Run exceeded %0d clock cycles", limit));
  end

  task automatic abort(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) abort($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic tick();
    @(posedge CLK);
    #1;
  endtask

  task automatic idle_gap();
    int gap;
    gap = 0;
    repeat (2) begin
      lfsr = lfsr_step(lfsr);
      gap  = (gap << 1) | int'(lfsr[0]);
    end
    repeat (gap) tick();
  endtask

  task automatic write_config();
    cfg_eew = eew_t'(fld[0][1:0]);
    cfg_vl  = fld[1][5:0];
    cfg_wen = 1'b1;
    tick();
    cfg_wen = 1'b0;
  endtask

  task automatic expect_held(input rob_result_t held);
    check("rob_out.wdata", rob_out.wdata, held.wdata);
    check("rob_out.ready", 64'(rob_out.ready), 64'(held.ready));
    check("rob_out.wen", 64'(rob_out.wen), 64'(held.wen));
  endtask

  task automatic run_operation();
    mem_req_t    r;
    rob_result_t held;
    logic        mem;
    r          = '0;
    r.valid    = 1'b1;
    r.load     = (fld[0] == 32'd1);
    r.store    = (fld[0] == 32'd2);
    r.wen      = fld[1][1:0];
    r.elem_idx = fld[2][4:0];
    r.addr0    = fld[3];
    r.addr1    = fld[4];
    r.sdata0   = fld[5];
    r.sdata1   = fld[6];
    r.vd       = fld[7][4:0];
    r.woffset  = fld[8][4:0];
    r.rob_idx  = fld[9][2:0];
    r.rd_wen   = fld[10][0];
    r.rd_sel   = fld[11][4:0];
    r.rd_data  = fld[12];
    mem        = r.load | r.store;
    req        = r;
    if (flush_after > 0) begin
      repeat (flush_after) tick();
      check("busy", 64'(busy), 64'(1));
      flush     = 1'b1;
      req.valid = 1'b0;
      tick();
      check("busy", 64'(busy), 64'(0));   // Sequencer back in idle
      flush     = 1'b0;
      req.valid = 1'b1;  // Same access once more
      repeat (4) tick();
      flush = 1'b1;      // Fifth edge would latch the result
      tick();
      flush     = 1'b0;
      req.valid = 1'b0;
      check("rob_out.ready", 64'(rob_out.ready), 64'(0));
      check("rob_out.wen", 64'(rob_out.wen), 64'(0));
      check("rob_out.wdata", rob_out.wdata, 64'(0));
      check("wb_out.rd_wen", 64'(wb_out.rd_wen), 64'(0));
      flush_after = 0;
      return;
    end
    if (stall_for > 0) begin
      held  = rob_out;
      stall = 1'b1;
      repeat (stall_for) begin
        tick();
        expect_held(held);
        if (mem) check("busy", 64'(busy), 64'(1));
      end
      stall = 1'b0;
    end
    do begin
      tick();
    end while (!rob_out.ready);
    req.valid = 1'b0;
    check("rob_out.rob_idx", 64'(rob_out.rob_idx), 64'(r.rob_idx));
    check("rob_out.vd", 64'(rob_out.vd), 64'(r.vd));
    check("rob_out.woffset", 64'(rob_out.woffset), 64'(r.woffset));
    check("rob_out.wen", 64'(rob_out.wen), 64'(fld[13][1:0]));
    check("rob_out.exception", 64'(rob_out.exception), 64'(fld[14][0]));
    check("rob_out.wdata", rob_out.wdata, {fld[15], fld[16]});
    check("wb_out.rd_wen", 64'(wb_out.rd_wen), 64'(r.rd_wen));
    check("wb_out.rd_sel", 64'(wb_out.rd_sel), 64'(r.rd_sel));
    check("wb_out.rd_data", 64'(wb_out.rd_data), 64'(r.rd_data));
    if (stall_for > 0) begin
      held  = rob_out;
      stall = 1'b1;
      repeat (stall_for) begin
        tick();
        expect_held(held);
      end
      stall = 1'b0;
      tick();
      check("rob_out.ready", 64'(rob_out.ready), 64'(0));  // Bubble after release
      stall_for = 0;
    end
  endtask

  initial begin
    int    fd;
    int    n;
    int    records;
    string tag;
    string line;
    nRST = 1'b0;
    cfg_wen = 1'b0;
    cfg_eew = EEW32;
    cfg_vl = '0;
    req = '0;
    stall = 1'b0;
    flush = 1'b0;
    lfsr = 32'd80185;
    cycles = 0;
    limit = 0;
    stall_for = 0;
    flush_after = 0;
    fd = $fopen("vmem_golden.txt", "r");
    if (fd == 0) abort("Could not open vmem_golden.txt");
    records = 0;
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 1 && line.getc(0) != "#") records++;
    end
    $fclose(fd);
    limit = 20 * records + 100;
    repeat (10) @(posedge CLK);
    #1 nRST = 1'b1;
    fd = $fopen("vmem_golden.txt", "r");
    while ($fscanf(fd, "%s", tag) == 1) begin
      if (tag == "#") begin
        n = $fgets(line, fd);
      end else begin
        if (tag == "C") begin
          n = $fscanf(fd, "%h %h", fld[0], fld[1]);
          if (n != 2) abort("Configuration record in golden file is incomplete");
          write_config();
        end else if (tag == "S" || tag == "F") begin
          n = $fscanf(fd, "%h", fld[0]);
          if (n != 1) abort("Directive in golden file has no cycle count");
          if (tag == "S") stall_for = fld[0];
          else flush_after = fld[0];
        end else if (tag == "O") begin
          n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                      fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7],
                      fld[8], fld[9], fld[10], fld[11], fld[12], fld[13], fld[14],
                      fld[15], fld[16]);
          if (n != 17) abort("Operation record in golden file is incomplete");
          run_operation();
        end else begin
          abort($sformatf("Unknown record type %s in golden file", tag));
        end
        idle_gap();
      end
    end
    $fclose(fd);
    $display("TEST PASSED");
    $finish;
  end

endmodule

// ==== vmem_cfg.sv ====
`timescale 1ns/1ps

module vmem_cfg
  import vmem_pkg::*;
#(
  parameter int VL_MAX = 32
) (
  input  logic       CLK,
  input  logic       nRST,
  input  logic       cfg_wen,
  input  eew_t       cfg_eew,
  input  logic [5:0] cfg_vl,
  output eew_t       eew,
  output logic [5:0] vl
);

  localparam logic [5:0] VL_CAP = 6'(VL_MAX);

  logic [5:0] vl_clamped;

  // Anything past the largest legal length is cut back
  assign vl_clamped = (cfg_vl > VL_CAP) ? VL_CAP : cfg_vl;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      eew <= EEW32;             // Word elements out of reset
      vl  <= VL_CAP;
    end else if (cfg_wen) begin
      eew <= cfg_eew;
      vl  <= vl_clamped;
    end
  end

endmodule

// ==== vmem_data_ram.sv ====
`timescale 1ns/1ps

module vmem_data_ram
  import vmem_pkg::*;
#(
  parameter int RAM_WORDS = 256
) (
  input  logic        CLK,
  input  logic        nRST,
  input  mem_port_t   mem_port,
  output logic [31:0] rdata,
  output logic        dhit
);

  localparam int AW = $clog2(RAM_WORDS);

  logic [31:0]   mem [RAM_WORDS];
  logic [AW-1:0] widx;

  assign widx = mem_port.addr[AW+1:2];  // Upper address bits wrap

  // Model starts out cleared
  initial begin
    for (int i = 0; i < RAM_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  always_ff @(posedge CLK) begin
    if (mem_port.wen) begin
      for (int b = 0; b < 4; b++) begin
        if (mem_port.byte_ena[b]) mem[widx][8*b +: 8] <= mem_port.wdata[8*b +: 8];
      end
    end
    if (mem_port.ren) rdata <= mem[widx];  // Held until the next read
  end

  // Fixed one-cycle hit
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      dhit <= 1'b0;
    end else begin
      dhit <= mem_port.ren | mem_port.wen;
    end
  end

endmodule

// ==== vmem_golden.txt ====
# C eew vl | S stall_cycles | F flush_after_cycles | all values hex
# O kind(0 alu 1 load 2 store) wen eidx addr0 addr1 sdata0 sdata1 vd woff rob rdw rds rdd xwen xexc xdata1 xdata0
O 0 3 00 CAFE0001 0BAD0002 00000000 00000000 0A 04 5 1 11 DEADBEEF 3 0 0BAD0002 CAFE0001
O 0 3 07 00000123 FFFFFFFF 00000000 00000000 1F 1C 2 0 00 00000000 3 0 FFFFFFFF 00000123
# Word store then word load
O 2 3 00 00000100 00000104 11223344 55667788 02 00 1 1 05 00000055 0 0 00000000 00000000
O 1 3 00 00000100 00000104 00000000 00000000 03 00 2 0 00 00000000 3 0 55667788 11223344
# Byte stores at offsets 1 2 0 3, then byte load
C 0 20
O 2 3 00 00000101 00000106 FFFFFFAA 000000BB 04 01 3 0 00 00000000 0 0 00000000 00000000
O 2 3 00 00000100 00000107 123456C0 000000D7 05 02 4 1 1A 0000ABCD 0 0 00000000 00000000
O 1 3 00 00000101 00000107 00000000 00000000 06 03 5 0 00 00000000 3 0 000000D7 000000AA
# Halfword stores and loads
C 1 20
O 2 3 00 00000102 00000104 1234FEDC 00004321 07 04 6 0 00 00000000 0 0 00000000 00000000
O 1 3 00 00000102 00000106 00000000 00000000 08 05 7 0 00 00000000 3 0 0000D7BB 0000FEDC
C 2 20
O 1 3 00 00000100 00000104 00000000 00000000 09 06 0 1 02 00000002 3 0 D7BB4321 FEDCAAC0
# Vector length masks lane 1
C 2 04
O 2 3 03 00000108 0000010C A5A5A5A5 5A5A5A5A 0A 07 1 0 00 00000000 0 0 00000000 00000000
O 1 3 03 00000108 0000010C 00000000 00000000 0B 08 2 0 00 00000000 1 0 00000000 A5A5A5A5
C 2 20
O 1 3 00 00000108 0000010C 00000000 00000000 0C 09 3 0 00 00000000 3 0 00000000 A5A5A5A5
C 2 28
O 1 3 1F 00000100 00000104 00000000 00000000 0D 0A 4 0 00 00000000 1 0 00000000 FEDCAAC0
# Misaligned accesses
C 1 20
O 2 3 00 00000111 00000112 0000FFFF 0000BEEF 0E 0B 5 0 00 00000000 0 1 00000000 00000000
C 2 20
O 2 3 00 00000116 0000011A 12345678 9ABCDEF0 0F 0C 6 0 00 00000000 0 1 00000000 00000000
O 1 3 00 00000110 00000114 00000000 00000000 10 0D 7 0 00 00000000 3 0 00000000 BEEF0000
O 1 3 00 00000102 00000104 00000000 00000000 11 0E 0 0 00 00000000 2 1 D7BB4321 00000000
# Stall and flush
S 4
O 0 3 00 00000042 00000043 00000000 00000000 12 0F 1 1 07 77777777 3 0 00000043 00000042
S 6
O 1 3 00 00000100 00000104 00000000 00000000 13 10 2 0 00 00000000 3 0 D7BB4321 FEDCAAC0
F 2
O 1 3 00 00000108 0000010C 00000000 00000000 14 11 3 1 09 00000009 3 0 00000000 A5A5A5A5
O 1 3 00 00000108 0000010C 00000000 00000000 15 12 4 0 00 00000000 3 0 00000000 A5A5A5A5

// ==== vmem_lane_sched.sv ====
`timescale 1ns/1ps

module vmem_lane_sched
  import vmem_pkg::*;
(
  input  logic       CLK,
  input  logic       nRST,
  input  mem_req_t   req,
  input  eew_t       eew,
  input  logic [5:0] vl,
  input  logic       dhit,
  input  logic       stall,
  input  logic       flush,
  output mem_port_t  mem_port,
  output lane_stat_t stat,
  output logic       busy
);

  // Lane 0 request is issued straight from IDLE
  typedef enum logic [2:0] {
    IDLE,
    WAIT0,
    REQ1,
    WAIT1,
    DONE
  } state_t;

  state_t      state, next_state;
  logic        mem_op;
  logic [1:0]  active;
  logic [1:0]  misalign;
  logic [1:0]  go;            // Active and aligned, will touch memory
  logic        issue0, issue1;
  logic [31:0] lane_addr;
  logic [31:0] lane_sdata;
  logic [1:0]  off;

  function automatic logic misaligned(eew_t w, logic [1:0] a);
    case (w)
      EEW8:    return 1'b0;
      EEW16:   return a[0];
      default: return |a;
    endcase
  endfunction

  function automatic logic [3:0] byte_mask(eew_t w, logic [1:0] a);
    case (w)
      EEW8:    return 4'b0001 << a;
      EEW16:   return 4'b0011 << a;
      default: return 4'b1111;
    endcase
  endfunction

  assign mem_op = req.valid & (req.load | req.store);

  // Masked off by wen or by the vector length
  assign active[0] = mem_op & req.wen[0] & ({1'b0, req.elem_idx} < vl);
  assign active[1] = mem_op & req.wen[1] & ({1'b0, req.elem_idx} + 6'd1 < vl);

  assign misalign[0] = misaligned(eew, req.addr0[1:0]);
  assign misalign[1] = misaligned(eew, req.addr1[1:0]);
  assign go          = active & ~misalign;

  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        if (mem_op) begin
          if (go[0])      next_state = WAIT0;
          else if (go[1]) next_state = REQ1;
          else            next_state = DONE;  // Nothing to access
        end
      end
      WAIT0:   if (dhit) next_state = go[1] ? REQ1 : DONE;
      REQ1:    next_state = WAIT1;
      WAIT1:   if (dhit) next_state = DONE;
      DONE:    if (!stall) next_state = IDLE;
      default: next_state = IDLE;
    endcase
    if (flush) next_state = IDLE;
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  assign issue0 = (state == IDLE) & mem_op & go[0] & ~flush;
  assign issue1 = (state == REQ1) & ~flush;

  // Lane select for the port
  assign lane_addr  = issue1 ? req.addr1 : req.addr0;
  assign lane_sdata = issue1 ? req.sdata1 : req.sdata0;
  assign off        = lane_addr[1:0];

  assign mem_port.ren      = (issue0 | issue1) & req.load;
  assign mem_port.wen      = (issue0 | issue1) & req.store;
  assign mem_port.addr     = {lane_addr[31:2], 2'b00};
  assign mem_port.wdata    = lane_sdata << {off, 3'b000};
  assign mem_port.byte_ena = byte_mask(eew, off);

  assign stat.active    = active;
  assign stat.exception = active & misalign;
  assign stat.arrived0  = (state == WAIT0) & dhit & req.load;
  assign stat.arrived1  = (state == WAIT1) & dhit & req.load;
  assign stat.done      = (state == DONE);

  // Drops in the cycle the result gets latched
  assign busy = ((state == IDLE) & mem_op) | (state == WAIT0) | (state == REQ1) |
                (state == WAIT1) | ((state == DONE) & stall);

endmodule

// ==== vmem_pkg.sv ====
package vmem_pkg;

  // Element width encoding, shared by the config block and the datapath
  typedef enum logic [1:0] {
    EEW8  = 2'd0,
    EEW16 = 2'd1,
    EEW32 = 2'd2
  } eew_t;

  // One operation from execute, two element lanes
  typedef struct packed {
    logic        valid;
    logic        load;
    logic        store;
    logic [31:0] addr0;     // ALU result of lane 0 for ALU ops
    logic [31:0] addr1;     // ALU result of lane 1 for ALU ops
    logic [31:0] sdata0;
    logic [31:0] sdata1;
    logic [4:0]  elem_idx;  // Element index of lane 0
    logic [4:0]  vd;
    logic [4:0]  woffset;
    logic [1:0]  wen;       // One bit per lane
    logic [2:0]  rob_idx;
    logic        rd_wen;
    logic [4:0]  rd_sel;
    logic [31:0] rd_data;
  } mem_req_t;

  // Data memory request port
  typedef struct packed {
    logic        ren;
    logic        wen;
    logic [31:0] addr;      // Always word aligned
    logic [31:0] wdata;
    logic [3:0]  byte_ena;
  } mem_port_t;

  // Lane status, sequencer to stage
  typedef struct packed {
    logic [1:0] active;
    logic [1:0] exception;
    logic       arrived0;
    logic       arrived1;
    logic       done;
  } lane_stat_t;

  typedef struct packed {
    logic        ready;
    logic [2:0]  rob_idx;
    logic [4:0]  vd;
    logic [4:0]  woffset;
    logic [1:0]  wen;
    logic        exception;
    logic [63:0] wdata;     // Lane 1 in upper half
  } rob_result_t;

  // Scalar pass-through
  typedef struct packed {
    logic        rd_wen;
    logic [4:0]  rd_sel;
    logic [31:0] rd_data;
  } scalar_wb_t;

endpackage

// ==== vmem_stage.sv ====
`timescale 1ns/1ps

module vmem_stage
  import vmem_pkg::*;
(
  input  logic        CLK,
  input  logic        nRST,
  input  mem_req_t    req,
  input  eew_t        eew,
  input  logic [31:0] rdata,
  input  lane_stat_t  stat,
  input  logic        stall,
  input  logic        flush,
  output rob_result_t rob_out,
  output scalar_wb_t  wb_out
);

  logic [31:0] data0, data1;     // Load buffer
  logic [31:0] load0, load1;     // Aligned load elements
  logic [31:0] wdat0, wdat1;
  logic [1:0]  load_ok;
  logic        is_alu;
  logic        complete;
  rob_result_t next_rob;
  scalar_wb_t  next_wb;

  // Move the element down to bit 0 and zero-extend
  function automatic logic [31:0] align_load(logic [31:0] word, logic [1:0] off, eew_t w);
    logic [31:0] shifted;
    shifted = word >> {off, 3'b000};
    case (w)
      EEW8:    return {24'd0, shifted[7:0]};
      EEW16:   return {16'd0, shifted[15:0]};
      default: return shifted;
    endcase
  endfunction

  always_ff @(posedge CLK) begin
    if (stat.arrived0) data0 <= rdata;
    if (stat.arrived1) data1 <= rdata;
  end

  assign load0 = align_load(data0, req.addr0[1:0], eew);
  assign load1 = align_load(data1, req.addr1[1:0], eew);

  assign is_alu   = req.valid & ~req.load & ~req.store;
  assign complete = is_alu | stat.done;
  assign load_ok  = stat.active & ~stat.exception;  // Lanes that really read

  always_comb begin
    wdat0 = '0;  // Stores report no data
    wdat1 = '0;
    if (is_alu) begin
      wdat0 = req.addr0;
      wdat1 = req.addr1;
    end else if (req.load) begin
      wdat0 = load_ok[0] ? load0 : '0;
      wdat1 = load_ok[1] ? load1 : '0;
    end
  end

  always_comb begin
    next_rob = '0;
    next_wb  = '0;
    if (complete) begin
      next_rob.ready     = 1'b1;
      next_rob.rob_idx   = req.rob_idx;
      next_rob.vd        = req.vd;
      next_rob.woffset   = req.woffset;
      next_rob.exception = |stat.exception;
      next_rob.wdata     = {wdat1, wdat0};
      if (is_alu)        next_rob.wen = req.wen;
      else if (req.load) next_rob.wen = load_ok;
      next_wb.rd_wen  = req.rd_wen;
      next_wb.rd_sel  = req.rd_sel;
      next_wb.rd_data = req.rd_data;
    end
  end

  // Result register, flush wins over stall
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      rob_out <= '0;
      wb_out  <= '0;
    end else if (flush) begin
      rob_out <= '0;
      wb_out  <= '0;
    end else if (!stall) begin
      rob_out <= next_rob;  // Bubble when nothing finishes
      wb_out  <= next_wb;
    end
  end

endmodule

// ==== vmem_top.sv ====
`timescale 1ns/1ps

module vmem_top
  import vmem_pkg::*;
#(
  parameter int RAM_WORDS = 256,
  parameter int VL_MAX    = 32
) (
  input  logic        CLK,
  input  logic        nRST,
  input  logic        cfg_wen,
  input  eew_t        cfg_eew,
  input  logic [5:0]  cfg_vl,
  input  mem_req_t    req,
  input  logic        stall,
  input  logic        flush,
  output logic        busy,
  output rob_result_t rob_out,
  output scalar_wb_t  wb_out
);

  eew_t        eew;
  logic [5:0]  vl;
  mem_port_t   mem_port;
  lane_stat_t  stat;
  logic [31:0] rdata;
  logic        dhit;

  vmem_cfg #(
    .VL_MAX(VL_MAX)
  ) u_cfg (
    .CLK, .nRST, .cfg_wen, .cfg_eew, .cfg_vl,
    .eew, .vl
  );

  vmem_lane_sched u_sched (
    .CLK, .nRST, .req, .eew, .vl, .dhit, .stall, .flush,
    .mem_port, .stat, .busy
  );

  vmem_stage u_stage (
    .CLK, .nRST, .req, .eew, .rdata, .stat, .stall, .flush,
    .rob_out, .wb_out
  );

  vmem_data_ram #(
    .RAM_WORDS(RAM_WORDS)
  ) u_ram (
    .CLK, .nRST, .mem_port,
    .rdata, .dhit
  );

endmodule
